/* src/soc_pkg.sv */
package soc_pkg;

    // Address and data word width.
    localparam int XLEN = 32;

    // Memory depth in 32-bit words, as a power of two.
    localparam int MEM_WORDS_LOG2 = 10;

    // Cycles from request acceptance to response in the memory model.
    localparam int MEM_DELAY = 4;

    // Core clock rate; one microsecond is CLK_MHZ cycles.
    localparam int CLK_MHZ = 27;

    // Width of the board LED register.
    localparam int LED_WIDTH = 6;

    // Addresses with bit 31 set belong to the MMIO region.
    localparam logic [XLEN-1:0] MMIO_BASE = 32'h8000_0000;

    // MMIO register map, byte offsets from MMIO_BASE.
    localparam logic [XLEN-1:0] MMIO_MTIME_LO    = 32'h0000_0000;
    localparam logic [XLEN-1:0] MMIO_MTIME_HI    = 32'h0000_0004;
    localparam logic [XLEN-1:0] MMIO_MTIMECMP_LO = 32'h0000_0008;
    localparam logic [XLEN-1:0] MMIO_MTIMECMP_HI = 32'h0000_000C;
    localparam logic [XLEN-1:0] MMIO_CYCLE_LO    = 32'h0000_0010;
    localparam logic [XLEN-1:0] MMIO_CYCLE_HI    = 32'h0000_0014;
    localparam logic [XLEN-1:0] MMIO_LED         = 32'h0000_0018;

    // Source tags carried through the arbiter response pipeline.
    localparam logic PORT_TAG_DATA = 1'b0;
    localparam logic PORT_TAG_INST = 1'b1;

endpackage

/* src/soc_timers.sv */
module soc_timers (
    input  logic        clk_in,
    input  logic        arst_n,
    output logic [63:0] cycle,
    output logic [63:0] mtime
);
    import soc_pkg::*;

    logic [$clog2(CLK_MHZ)-1:0] prescaler;
    logic                       us_tick;

    // One tick per microsecond of wall time.
    assign us_tick = (prescaler == CLK_MHZ - 1);

    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            cycle <= '0;
        end else begin
            cycle <= cycle + 64'd1;
        end
    end

    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            prescaler <= '0;
            mtime     <= '0;
        end else if (us_tick) begin
            prescaler <= '0;
            mtime     <= mtime + 64'd1;
        end else begin
            prescaler <= prescaler + 1'b1;
        end
    end

    // Prescaler wraps before leaving its range.
    a_prescaler_range: assert property (
        @(posedge clk_in) disable iff (!arst_n)
        prescaler <= CLK_MHZ - 1
    );

endmodule

/* src/mem_model.sv */
module mem_model (
    input  logic                     clk_in,
    input  logic                     arst_n,
    input  logic                     mreq_valid,
    input  logic [soc_pkg::XLEN-1:0] mreq_addr,
    input  logic                     mreq_wen,
    input  logic [soc_pkg::XLEN-1:0] mreq_wdata,
    output logic                     mresp_valid,
    output logic                     mresp_error,
    output logic [soc_pkg::XLEN-1:0] mresp_rdata
);
    import soc_pkg::*;

    // Word storage, zero at power-up.
    logic [XLEN-1:0] mem [2**MEM_WORDS_LOG2] = '{default: '0};

    logic [MEM_WORDS_LOG2-1:0]       word_idx;
    logic                            addr_error;
    logic [XLEN-1:0]                 read_word;

    logic [MEM_DELAY-1:0]            valid_pipe;
    logic [MEM_DELAY-1:0]            error_pipe;
    logic [MEM_DELAY-1:0][XLEN-1:0]  rdata_pipe;

    always_comb begin
        word_idx = mreq_addr[MEM_WORDS_LOG2+1:2];
        // Misaligned or beyond the last word.
        addr_error = (mreq_addr[1:0] != 2'b00) ||
                     (mreq_addr[XLEN-1:MEM_WORDS_LOG2+2] != '0);
        if (mreq_wen || addr_error) begin
            read_word = '0;
        end else begin
            read_word = mem[word_idx];
        end
    end

    // Writes land on the accepting edge.
    always_ff @(posedge clk_in) begin
        if (mreq_valid && mreq_wen && !addr_error) begin
            mem[word_idx] <= mreq_wdata;
        end
    end

    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            valid_pipe <= '0;
        end else begin
            valid_pipe <= {valid_pipe[MEM_DELAY-2:0], mreq_valid};
        end
    end

    // Payload follows valid through the delay line.
    always_ff @(posedge clk_in) begin
        error_pipe <= {error_pipe[MEM_DELAY-2:0], addr_error};
        rdata_pipe <= {rdata_pipe[MEM_DELAY-2:0], read_word};
    end

    assign mresp_valid = valid_pipe[MEM_DELAY-1];
    assign mresp_error = error_pipe[MEM_DELAY-1];
    assign mresp_rdata = rdata_pipe[MEM_DELAY-1];

    a_addr_known: assert property (
        @(posedge clk_in) disable iff (!arst_n)
        mreq_valid |-> !$isunknown(mreq_addr)
    );

endmodule

/* src/mem_bus_arbiter.sv */
module mem_bus_arbiter (
    input  logic                     clk_in,
    input  logic                     arst_n,

    input  logic                     ireq_valid,
    output logic                     ireq_ready,
    input  logic [soc_pkg::XLEN-1:0] ireq_addr,
    output logic                     iresp_valid,
    output logic                     iresp_error,
    output logic [soc_pkg::XLEN-1:0] iresp_rdata,

    input  logic                     dreq_valid,
    output logic                     dreq_ready,
    input  logic [soc_pkg::XLEN-1:0] dreq_addr,
    input  logic                     dreq_wen,
    input  logic [soc_pkg::XLEN-1:0] dreq_wdata,
    output logic                     dresp_valid,
    output logic                     dresp_error,
    output logic [soc_pkg::XLEN-1:0] dresp_rdata,

    output logic                     mreq_valid,
    output logic [soc_pkg::XLEN-1:0] mreq_addr,
    output logic                     mreq_wen,
    output logic [soc_pkg::XLEN-1:0] mreq_wdata,
    input  logic                     mresp_valid,
    input  logic                     mresp_error,
    input  logic [soc_pkg::XLEN-1:0] mresp_rdata
);
    import soc_pkg::*;

    logic                 last_tag;
    logic                 grant_data;
    logic                 grant_inst;
    logic [MEM_DELAY-1:0] tag_pipe;
    logic [MEM_DELAY-1:0] tag_valid_pipe;
    logic                 resp_tag;

    // Ready is offered to a port unless the other one wins the tie.
    assign dreq_ready = !ireq_valid || (last_tag == PORT_TAG_INST);
    assign ireq_ready = !dreq_valid || (last_tag == PORT_TAG_DATA);
    assign grant_data = dreq_valid && dreq_ready;
    assign grant_inst = ireq_valid && ireq_ready;

    always_comb begin
        mreq_valid = grant_data || grant_inst;
        if (grant_data) begin
            mreq_addr  = dreq_addr;
            mreq_wen   = dreq_wen;
            mreq_wdata = dreq_wdata;
        end else begin
            mreq_addr  = ireq_addr;
            mreq_wen   = 1'b0;
            mreq_wdata = '0;
        end
    end

    // Reset to the fetch tag so data wins the first tie.
    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            last_tag       <= PORT_TAG_INST;
            tag_valid_pipe <= '0;
        end else begin
            if (mreq_valid) begin
                last_tag <= grant_data ? PORT_TAG_DATA : PORT_TAG_INST;
            end
            tag_valid_pipe <= {tag_valid_pipe[MEM_DELAY-2:0], mreq_valid};
        end
    end

    always_ff @(posedge clk_in) begin
        tag_pipe <= {tag_pipe[MEM_DELAY-2:0], grant_data ? PORT_TAG_DATA : PORT_TAG_INST};
    end

    assign resp_tag = tag_pipe[MEM_DELAY-1];

    assign dresp_valid = mresp_valid && (resp_tag == PORT_TAG_DATA);
    assign iresp_valid = mresp_valid && (resp_tag == PORT_TAG_INST);
    assign dresp_error = mresp_error;
    assign iresp_error = mresp_error;
    assign dresp_rdata = mresp_rdata;
    assign iresp_rdata = mresp_rdata;

    a_single_grant: assert property (
        @(posedge clk_in) disable iff (!arst_n)
        (ireq_valid && dreq_valid) |-> !(ireq_ready && dreq_ready)
    );

    // Memory latency must line up with the tag pipeline depth.
    a_resp_tagged: assert property (
        @(posedge clk_in) disable iff (!arst_n)
        mresp_valid |-> tag_valid_pipe[MEM_DELAY-1]
    );

endmodule

/* src/mmio_ctrl.sv */
module mmio_ctrl (
    input  logic                          clk_in,
    input  logic                          arst_n,

    input  logic                          req_valid,
    output logic                          req_ready,
    input  logic [soc_pkg::XLEN-1:0]      req_addr,
    input  logic                          req_wen,
    input  logic [soc_pkg::XLEN-1:0]      req_wdata,
    output logic                          resp_valid,
    output logic                          resp_error,
    output logic [soc_pkg::XLEN-1:0]      resp_rdata,

    input  logic [63:0]                   cycle,
    input  logic [63:0]                   mtime,

    output logic                          mem_req_valid,
    input  logic                          mem_ready,
    output logic [soc_pkg::XLEN-1:0]      mem_req_addr,
    output logic                          mem_req_wen,
    output logic [soc_pkg::XLEN-1:0]      mem_req_wdata,
    input  logic                          mem_resp_valid,
    input  logic                          mem_resp_error,
    input  logic [soc_pkg::XLEN-1:0]      mem_resp_rdata,

    output logic [soc_pkg::LED_WIDTH-1:0] led,
    output logic                          timer_irq
);
    import soc_pkg::*;

    logic                           is_mmio;
    logic                           mmio_fire;
    logic [$clog2(MEM_DELAY+1)-1:0] pending;
    logic [63:0]                    mtimecmp;
    logic [LED_WIDTH-1:0]           led_reg;
    logic [XLEN-1:0]                rd_data;
    logic                           rd_error;
    logic                           mmio_resp_valid;
    logic                           mmio_resp_error;
    logic [XLEN-1:0]                mmio_resp_rdata;

    assign is_mmio = req_addr[XLEN-1];

    // Memory traffic passes straight through to the arbiter.
    assign mem_req_valid = req_valid && !is_mmio;
    assign mem_req_addr  = req_addr;
    assign mem_req_wen   = req_wen;
    assign mem_req_wdata = req_wdata;

    // MMIO waits until all earlier memory accesses have answered.
    assign req_ready = is_mmio ? (pending == '0) : mem_ready;
    assign mmio_fire = req_valid && is_mmio && (pending == '0);

    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            pending <= '0;
        end else begin
            pending <= pending + (mem_req_valid && mem_ready) - mem_resp_valid;
        end
    end

    always_comb begin
        rd_data  = '0;
        rd_error = 1'b0;
        case (req_addr)
            MMIO_BASE | MMIO_MTIME_LO:    rd_data = mtime[XLEN-1:0];
            MMIO_BASE | MMIO_MTIME_HI:    rd_data = mtime[2*XLEN-1:XLEN];
            MMIO_BASE | MMIO_MTIMECMP_LO: rd_data = mtimecmp[XLEN-1:0];
            MMIO_BASE | MMIO_MTIMECMP_HI: rd_data = mtimecmp[2*XLEN-1:XLEN];
            MMIO_BASE | MMIO_CYCLE_LO:    rd_data = cycle[XLEN-1:0];
            MMIO_BASE | MMIO_CYCLE_HI:    rd_data = cycle[2*XLEN-1:XLEN];
            MMIO_BASE | MMIO_LED:         rd_data = {{(XLEN-LED_WIDTH){1'b0}}, led_reg};
            // Unmapped or misaligned.
            default:                      rd_error = 1'b1;
        endcase
    end

    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            mtimecmp <= '1;
            led_reg  <= '0;
        end else if (mmio_fire && req_wen) begin
            case (req_addr)
                MMIO_BASE | MMIO_MTIMECMP_LO: mtimecmp[XLEN-1:0] <= req_wdata;
                MMIO_BASE | MMIO_MTIMECMP_HI: mtimecmp[2*XLEN-1:XLEN] <= req_wdata;
                MMIO_BASE | MMIO_LED:         led_reg <= req_wdata[LED_WIDTH-1:0];
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            mmio_resp_valid <= 1'b0;
        end else begin
            mmio_resp_valid <= mmio_fire;
        end
    end

    // Writes answer with zero data.
    always_ff @(posedge clk_in) begin
        if (mmio_fire) begin
            mmio_resp_error <= rd_error;
            mmio_resp_rdata <= req_wen ? '0 : rd_data;
        end
    end

    assign resp_valid = mmio_resp_valid || mem_resp_valid;
    assign resp_error = mmio_resp_valid ? mmio_resp_error : mem_resp_error;
    assign resp_rdata = mmio_resp_valid ? mmio_resp_rdata : mem_resp_rdata;

    assign led       = ~led_reg;
    assign timer_irq = (mtime >= mtimecmp);

    // The drain rule keeps the two response sources apart.
    a_no_resp_overlap: assert property (
        @(posedge clk_in) disable iff (!arst_n)
        !(mmio_resp_valid && mem_resp_valid)
    );

endmodule

/* src/mem_subsystem_top.sv */
module mem_subsystem_top (
    input  logic                          clk_in,
    input  logic                          arst_n,

    input  logic                          ireq_valid,
    output logic                          ireq_ready,
    input  logic [soc_pkg::XLEN-1:0]      ireq_addr,
    output logic                          iresp_valid,
    output logic                          iresp_error,
    output logic [soc_pkg::XLEN-1:0]      iresp_rdata,

    input  logic                          dreq_valid,
    output logic                          dreq_ready,
    input  logic [soc_pkg::XLEN-1:0]      dreq_addr,
    input  logic                          dreq_wen,
    input  logic [soc_pkg::XLEN-1:0]      dreq_wdata,
    output logic                          dresp_valid,
    output logic                          dresp_error,
    output logic [soc_pkg::XLEN-1:0]      dresp_rdata,

    output logic [soc_pkg::LED_WIDTH-1:0] led,
    output logic                          timer_irq
);
    import soc_pkg::*;

    logic [63:0]     cycle;
    logic [63:0]     mtime;

    // Data path between the MMIO controller and the arbiter.
    logic            md_req_valid;
    logic            md_req_ready;
    logic [XLEN-1:0] md_req_addr;
    logic            md_req_wen;
    logic [XLEN-1:0] md_req_wdata;
    logic            md_resp_valid;
    logic            md_resp_error;
    logic [XLEN-1:0] md_resp_rdata;

    // Memory bus.
    logic            mreq_valid;
    logic [XLEN-1:0] mreq_addr;
    logic            mreq_wen;
    logic [XLEN-1:0] mreq_wdata;
    logic            mresp_valid;
    logic            mresp_error;
    logic [XLEN-1:0] mresp_rdata;

    soc_timers soc_timers_i (
        .clk_in (clk_in),
        .arst_n (arst_n),
        .cycle  (cycle),
        .mtime  (mtime)
    );

    mmio_ctrl mmio_ctrl_i (
        .clk_in         (clk_in),
        .arst_n         (arst_n),
        .req_valid      (dreq_valid),
        .req_ready      (dreq_ready),
        .req_addr       (dreq_addr),
        .req_wen        (dreq_wen),
        .req_wdata      (dreq_wdata),
        .resp_valid     (dresp_valid),
        .resp_error     (dresp_error),
        .resp_rdata     (dresp_rdata),
        .cycle          (cycle),
        .mtime          (mtime),
        .mem_req_valid  (md_req_valid),
        .mem_ready      (md_req_ready),
        .mem_req_addr   (md_req_addr),
        .mem_req_wen    (md_req_wen),
        .mem_req_wdata  (md_req_wdata),
        .mem_resp_valid (md_resp_valid),
        .mem_resp_error (md_resp_error),
        .mem_resp_rdata (md_resp_rdata),
        .led            (led),
        .timer_irq      (timer_irq)
    );

    mem_bus_arbiter mem_bus_arbiter_i (
        .clk_in      (clk_in),
        .arst_n      (arst_n),
        .ireq_valid  (ireq_valid),
        .ireq_ready  (ireq_ready),
        .ireq_addr   (ireq_addr),
        .iresp_valid (iresp_valid),
        .iresp_error (iresp_error),
        .iresp_rdata (iresp_rdata),
        .dreq_valid  (md_req_valid),
        .dreq_ready  (md_req_ready),
        .dreq_addr   (md_req_addr),
        .dreq_wen    (md_req_wen),
        .dreq_wdata  (md_req_wdata),
        .dresp_valid (md_resp_valid),
        .dresp_error (md_resp_error),
        .dresp_rdata (md_resp_rdata),
        .mreq_valid  (mreq_valid),
        .mreq_addr   (mreq_addr),
        .mreq_wen    (mreq_wen),
        .mreq_wdata  (mreq_wdata),
        .mresp_valid (mresp_valid),
        .mresp_error (mresp_error),
        .mresp_rdata (mresp_rdata)
    );

    mem_model mem_model_i (
        .clk_in      (clk_in),
        .arst_n      (arst_n),
        .mreq_valid  (mreq_valid),
        .mreq_addr   (mreq_addr),
        .mreq_wen    (mreq_wen),
        .mreq_wdata  (mreq_wdata),
        .mresp_valid (mresp_valid),
        .mresp_error (mresp_error),
        .mresp_rdata (mresp_rdata)
    );

endmodule

/* dv/tb_mem_subsystem.sv */
module tb_mem_subsystem;
    timeunit 1ns;
    timeprecision 1ps;

    import soc_pkg::*;

    localparam int N_OPS      = 400;
    localparam int WAIT_LIMIT = 200;

    // One expected response, queued when its request is accepted.
    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] lo;
        logic [31:0] hi;
        logic [31:0] due;
        logic        err;
        logic        ranged;
    } exp_t;

    logic                 clk_in = 1'b0;
    logic                 arst_n;
    logic                 ireq_valid;
    logic                 ireq_ready;
    logic [XLEN-1:0]      ireq_addr;
    logic                 iresp_valid;
    logic                 iresp_error;
    logic [XLEN-1:0]      iresp_rdata;
    logic                 dreq_valid;
    logic                 dreq_ready;
    logic [XLEN-1:0]      dreq_addr;
    logic                 dreq_wen;
    logic [XLEN-1:0]      dreq_wdata;
    logic                 dresp_valid;
    logic                 dresp_error;
    logic [XLEN-1:0]      dresp_rdata;
    logic [LED_WIDTH-1:0] led;
    logic                 timer_irq;

    integer               seed;
    int                   errors;
    logic [31:0]          cyc;
    logic [31:0]          shadow_mem [2**MEM_WORDS_LOG2];
    logic [63:0]          shadow_cmp;
    logic [LED_WIDTH-1:0] shadow_led;
    exp_t                 data_q [$];
    exp_t                 inst_q [$];
    logic [31:0]          d_addr [N_OPS];
    logic                 d_wen [N_OPS];
    logic [31:0]          d_wdata [N_OPS];
    int                   d_gap [N_OPS];
    logic [31:0]          f_addr [N_OPS];
    int                   f_gap [N_OPS];

    mem_subsystem_top mem_subsystem_top_i (
        .clk_in      (clk_in),
        .arst_n      (arst_n),
        .ireq_valid  (ireq_valid),
        .ireq_ready  (ireq_ready),
        .ireq_addr   (ireq_addr),
        .iresp_valid (iresp_valid),
        .iresp_error (iresp_error),
        .iresp_rdata (iresp_rdata),
        .dreq_valid  (dreq_valid),
        .dreq_ready  (dreq_ready),
        .dreq_addr   (dreq_addr),
        .dreq_wen    (dreq_wen),
        .dreq_wdata  (dreq_wdata),
        .dresp_valid (dresp_valid),
        .dresp_error (dresp_error),
        .dresp_rdata (dresp_rdata),
        .led         (led),
        .timer_irq   (timer_irq)
    );

    always #50 clk_in = ~clk_in;

    // Cycles since reset release, matching the DUT cycle counter.
    always @(posedge clk_in) begin
        if (arst_n) begin
            cyc <= cyc + 32'd1;
        end
    end

    task automatic make_ops;
        logic [31:0] r;
        logic [31:0] word;
        for (int i = 0; i < N_OPS; i++) begin
            r = $random(seed);
            word = {24'b0, r[13:8], 2'b00};
            d_wen[i] = 1'b0;
            d_wdata[i] = $random(seed);
            if (r[3:0] < 4'd5) begin
                d_addr[i] = word;
                d_wen[i]  = 1'b1;
            end else if (r[3:0] < 4'd10) begin
                d_addr[i] = word;
            end else if (r[3:0] == 4'd10) begin
                d_addr[i] = word | {30'b0, r[17], 1'b1};
            end else if (r[3:0] == 4'd11) begin
                d_addr[i] = {1'b0, r[30:18], 18'b0} | 32'h0000_1000;
                d_wen[i]  = r[4];
            end else begin
                d_addr[i] = MMIO_BASE | {26'b0, r[21:16]};
                d_wen[i]  = r[3:0] > 4'd13;
            end
            // Second half keeps both ports busy every cycle.
            d_gap[i] = (i < N_OPS / 2 && r[7:6] == 2'b00) ? int'(r[24:23]) + 1 : 0;
            r = $random(seed);
            if (r[2:0] == 3'd6) begin
                f_addr[i] = {24'b0, r[13:8], r[15], 1'b1};
            end else if (r[2:0] == 3'd7) begin
                f_addr[i] = {1'b0, r[30:18], 18'b0} | 32'h0000_1000;
            end else begin
                f_addr[i] = {24'b0, r[13:8], 2'b00};
            end
            f_gap[i] = (i < N_OPS / 2 && r[5:4] == 2'b00) ? int'(r[17:16]) + 1 : 0;
        end
    endtask

    task automatic send_req(input logic port, input logic [31:0] addr, input logic wen,
                            input logic [31:0] wdata);
        int waited;
        if (port) begin
            ireq_valid <= 1'b1;
            ireq_addr  <= addr;
        end else begin
            dreq_valid <= 1'b1;
            dreq_addr  <= addr;
            dreq_wen   <= wen;
            dreq_wdata <= wdata;
        end
        waited = 0;
        @(negedge clk_in);
        while (!(port ? ireq_ready : dreq_ready) && waited < WAIT_LIMIT) begin
            waited++;
            @(negedge clk_in);
        end
        if (!(port ? ireq_ready : dreq_ready)) begin
            errors++;
            $display("Timeout: request to %h on the %s port was never accepted",
                     addr, port ? "fetch" : "data");
        end
        @(posedge clk_in);
        if (port) begin
            ireq_valid <= 1'b0;
        end else begin
            dreq_valid <= 1'b0;
        end
    endtask

    task automatic wait_irq(input logic level);
        int waited;
        waited = 0;
        @(negedge clk_in);
        while (timer_irq !== level && waited < 8 * CLK_MHZ) begin
            waited++;
            @(negedge clk_in);
        end
        if (timer_irq !== level) begin
            errors++;
            $display("Timeout: timer_irq never went to %0d", level);
        end
        @(posedge clk_in);
    endtask

    task automatic expect_mem(input logic [31:0] addr, input logic wen,
                              input logic [31:0] wdata, output exp_t e);
        e = '0;
        e.addr = addr;
        e.due  = cyc + MEM_DELAY;
        e.err  = (addr[1:0] != 2'b00) || ((addr >> (MEM_WORDS_LOG2 + 2)) != 0);
        if (wen && !e.err) begin
            shadow_mem[addr[MEM_WORDS_LOG2+1:2]] = wdata;
        end else if (!wen && !e.err) begin
            e.data = shadow_mem[addr[MEM_WORDS_LOG2+1:2]];
        end
    endtask

    task automatic accept_data;
        exp_t        e;
        logic [31:0] off;
        logic [63:0] lo64;
        logic [63:0] hi64;
        if (!dreq_addr[XLEN-1]) begin
            expect_mem(dreq_addr, dreq_wen, dreq_wdata, e);
        end else begin
            e = '0;
            e.addr = dreq_addr;
            e.due  = cyc + 1;
            off    = dreq_addr ^ MMIO_BASE;
            if (data_q.size() != 0) begin
                errors++;
                $display("MMIO request to %h accepted before earlier memory responses", dreq_addr);
            end
            case (off)
                MMIO_MTIME_LO, MMIO_MTIME_HI, MMIO_CYCLE_LO, MMIO_CYCLE_HI: begin
                    // Counter value is taken somewhere between acceptance and response.
                    lo64 = {32'b0, cyc};
                    hi64 = {32'b0, cyc} + 64'd1;
                    if (off == MMIO_MTIME_LO || off == MMIO_MTIME_HI) begin
                        lo64 = lo64 / CLK_MHZ;
                        hi64 = hi64 / CLK_MHZ;
                    end
                    e.ranged = !dreq_wen;
                    e.lo = off[2] ? lo64[63:32] : lo64[31:0];
                    e.hi = off[2] ? hi64[63:32] : hi64[31:0];
                end
                MMIO_MTIMECMP_LO, MMIO_MTIMECMP_HI: begin
                    if (dreq_wen && off[2]) begin
                        shadow_cmp[63:32] = dreq_wdata;
                    end else if (dreq_wen) begin
                        shadow_cmp[31:0] = dreq_wdata;
                    end else begin
                        e.data = off[2] ? shadow_cmp[63:32] : shadow_cmp[31:0];
                    end
                end
                MMIO_LED: begin
                    if (dreq_wen) begin
                        shadow_led = dreq_wdata[LED_WIDTH-1:0];
                    end else begin
                        e.data = {{(XLEN-LED_WIDTH){1'b0}}, shadow_led};
                    end
                end
                default: e.err = 1'b1;
            endcase
        end
        data_q.push_back(e);
    endtask

    task automatic check_resp(input logic port, input logic valid, input logic err,
                              input logic [31:0] data);
        exp_t  e;
        string name;
        int    n;
        name = port ? "iresp" : "dresp";
        n = port ? inst_q.size() : data_q.size();
        if (n == 0) begin
            if (valid) begin
                errors++;
                $display("%s_valid pulsed with no request outstanding", name);
            end
        end else begin
            e = port ? inst_q[0] : data_q[0];
            if (valid || e.due <= cyc) begin
                if (port) begin
                    void'(inst_q.pop_front());
                end else begin
                    void'(data_q.pop_front());
                end
                if (!valid) begin
                    errors++;
                    $display("No %s_valid for the request to %h due at cycle %0d",
                             name, e.addr, e.due);
                end else begin
                    if (e.due != cyc) begin
                        errors++;
                        $display("%s_valid for %h came at cycle %0d instead of %0d",
                                 name, e.addr, cyc, e.due);
                    end
                    if (err !== e.err) begin
                        errors++;
                        $display("Mismatch %s_error: expected %h, got %h", name, e.err, err);
                    end
                    if (e.ranged) begin
                        if (data < e.lo || data > e.hi) begin
                            errors++;
                            $display("Mismatch %s_rdata: expected %h to %h, got %h",
                                     name, e.lo, e.hi, data);
                        end
                    end else if (data !== e.data) begin
                        errors++;
                        $display("Mismatch %s_rdata: expected %h, got %h", name, e.data, data);
                    end
                end
            end
        end
    endtask

    // Outputs are stable at the falling edge; requests seen here are accepted at the next rise.
    always @(negedge clk_in) begin
        logic   irq_exp;
        exp_t   e;
        if (arst_n) begin
            check_resp(1'b0, dresp_valid, dresp_error, dresp_rdata);
            check_resp(1'b1, iresp_valid, iresp_error, iresp_rdata);
            if (led !== ~shadow_led) begin
                errors++;
                $display("Mismatch led: expected %h, got %h", ~shadow_led, led);
            end
            irq_exp = (({32'b0, cyc} / CLK_MHZ) >= shadow_cmp);
            if (timer_irq !== irq_exp) begin
                errors++;
                $display("Mismatch timer_irq: expected %h, got %h", irq_exp, timer_irq);
            end
            if (dreq_valid && dreq_ready) begin
                accept_data();
            end
            if (ireq_valid && ireq_ready) begin
                expect_mem(ireq_addr, 1'b0, '0, e);
                inst_q.push_back(e);
            end
        end
    end

    task automatic run_data;
        for (int i = 0; i < N_OPS; i++) begin
            send_req(1'b0, d_addr[i], d_wen[i], d_wdata[i]);
            repeat (d_gap[i]) @(posedge clk_in);
        end
        // Small compare value, then raise it again.
        send_req(1'b0, MMIO_BASE | MMIO_MTIMECMP_LO, 1'b1, 32'hffff_ffff);
        send_req(1'b0, MMIO_BASE | MMIO_MTIMECMP_HI, 1'b1, 32'h0);
        send_req(1'b0, MMIO_BASE | MMIO_MTIMECMP_LO, 1'b1, cyc / CLK_MHZ + 3);
        wait_irq(1'b1);
        send_req(1'b0, MMIO_BASE | MMIO_MTIMECMP_LO, 1'b1, 32'hffff_ffff);
        wait_irq(1'b0);
    endtask

    task automatic run_fetch;
        for (int i = 0; i < N_OPS; i++) begin
            send_req(1'b1, f_addr[i], 1'b0, '0);
            repeat (f_gap[i]) @(posedge clk_in);
        end
    endtask

    initial begin
        int waited;
        seed       = 32'h338a;
        errors     = 0;
        cyc        = '0;
        arst_n     = 1'b0;
        ireq_valid = 1'b0;
        ireq_addr  = '0;
        dreq_valid = 1'b0;
        dreq_addr  = '0;
        dreq_wen   = 1'b0;
        dreq_wdata = '0;
        shadow_cmp = '1;
        shadow_led = '0;
        for (int i = 0; i < 2**MEM_WORDS_LOG2; i++) begin
            shadow_mem[i] = '0;
        end
        make_ops();
        repeat (8) @(posedge clk_in);
        arst_n <= 1'b1;
        @(negedge clk_in);
        if (timer_irq !== 1'b0) begin
            errors++;
            $display("Mismatch timer_irq after reset: expected 0, got %h", timer_irq);
        end
        @(posedge clk_in);
        fork
            run_data();
            run_fetch();
        join
        waited = 0;
        while ((data_q.size() != 0 || inst_q.size() != 0) && waited < WAIT_LIMIT) begin
            waited++;
            @(negedge clk_in);
        end
        if (data_q.size() != 0 || inst_q.size() != 0) begin
            errors++;
            $display("Timeout: responses still outstanding at the end of the run");
        end
        $display("Run finished with %0d errors", errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* flist.f */
src/soc_pkg.sv
src/soc_timers.sv
src/mem_model.sv
src/mem_bus_arbiter.sv
src/mmio_ctrl.sv
src/mem_subsystem_top.sv
dv/tb_mem_subsystem.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the memory subsystem testbench with Verilator.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module tb_mem_subsystem -f flist.f

status=0
./obj_dir/Vtb_mem_subsystem > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "=== FAIL ===" sim.log; then
    echo "Simulation failed"
    exit 1
fi
if [ "$status" -ne 0 ] || ! grep -q "=== PASS ===" sim.log; then
    echo "Simulation did not complete"
    exit 1
fi
echo "Simulation passed"
